//--- rtl/IsaPkg.sv
`default_nettype none

package IsaPkg;

    // Data word and register index
    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;

    // Decoded micro-op opcodes
    typedef enum logic [3:0] {
        OpAdd,
        OpSub,
        OpAnd,
        OpOr,
        OpXor,
        OpSll,
        OpAddi,
        OpLw,
        OpSw
    } opcode_t;

    // One decoded instruction
    typedef struct packed {
        opcode_t op;
        regAddr_t rd;
        regAddr_t rs1;
        regAddr_t rs2;
        word_t imm;
    } MicroOp;

    // Ops whose rd value is known at the end of execute
    function automatic logic isAluOp(opcode_t op);
        return op inside {OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSll, OpAddi};
    endfunction

endpackage

`default_nettype wire

//--- rtl/PipelinePkg.sv
`default_nettype none

package PipelinePkg;

    // One in-flight result visible to the bypass CAM
    typedef struct packed {
        logic valid;
        IsaPkg::regAddr_t addr;
        IsaPkg::word_t value;
    } BypassEntry;

    // Execute-to-memory register
    typedef struct packed {
        logic valid;
        IsaPkg::opcode_t op;
        IsaPkg::regAddr_t rd;
        IsaPkg::word_t result;     // ALU result, or byte address for lw/sw
        IsaPkg::word_t storeData;
    } MemStageReg;

    // What leaves the retire port
    typedef struct packed {
        logic regWrite;
        IsaPkg::regAddr_t rd;
        IsaPkg::word_t value;
    } RetireRecord;

endpackage

`default_nettype wire

//--- rtl/IssueStage.sv
`timescale 1ns/10ps
`default_nettype none

module IssueStage (
    input wire clk,
    input wire rst,
    input wire advance,
    input wire inValid,
    input wire IsaPkg::MicroOp inOp,
    output logic inReady,
    output logic exValid,
    output IsaPkg::MicroOp exOp
);

    // Whole pipeline moves together, so the input is open whenever it advances
    assign inReady = advance;

    always_ff @(posedge clk) begin
        if (rst) begin
            exValid <= 1'b0;
        end else if (advance) begin
            // A cycle without input leaves a bubble behind
            exValid <= inValid;
            exOp <= inOp;
        end
    end

    // Upstream only offers opcodes the back end implements
    assert property (@(posedge clk) disable iff (rst)
        inValid |-> inOp.op inside {
            IsaPkg::OpAdd,
            IsaPkg::OpSub,
            IsaPkg::OpAnd,
            IsaPkg::OpOr,
            IsaPkg::OpXor,
            IsaPkg::OpSll,
            IsaPkg::OpAddi,
            IsaPkg::OpLw,
            IsaPkg::OpSw
        })
    else $error("IssueStage: unknown opcode offered on input");

endmodule

`default_nettype wire

//--- rtl/RegFile.sv
`timescale 1ns/10ps
`default_nettype none

module RegFile (
    input wire clk,
    input wire rst,
    input wire IsaPkg::regAddr_t readAddr1,
    input wire IsaPkg::regAddr_t readAddr2,
    output IsaPkg::word_t readValue1,
    output IsaPkg::word_t readValue2,
    input wire writeEnable,
    input wire IsaPkg::regAddr_t writeAddr,
    input wire IsaPkg::word_t writeValue
);

    // x0 has no storage
    IsaPkg::word_t regs [1:31];

    assign readValue1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readValue2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeValue;
        end
    end

    // Retire logic already drops x0 writes
    assert property (@(posedge clk) disable iff (rst)
        writeEnable |-> writeAddr != '0)
    else $error("RegFile: write to x0 reached the register file");

endmodule

`default_nettype wire

//--- rtl/BypassNetwork.sv
`timescale 1ns/10ps
`default_nettype none

module BypassNetwork #(
    parameter int BypassDepth = 2
) (
    input wire clk,
    input wire rst,
    input wire stall,
    input wire IsaPkg::regAddr_t readAddr1,
    input wire IsaPkg::regAddr_t readAddr2,
    input wire IsaPkg::word_t regValue1,
    input wire IsaPkg::word_t regValue2,
    output IsaPkg::word_t operand1,
    output IsaPkg::word_t operand2,
    input wire writeEnable,
    input wire IsaPkg::regAddr_t writeAddr,
    input wire IsaPkg::word_t writeValue,
    input wire loadWriteEnable,
    input wire IsaPkg::regAddr_t loadWriteAddr,
    input wire IsaPkg::word_t loadWriteValue
);

    // Entry 0 is one op ahead of execute, entry 1 two ops ahead
    PipelinePkg::BypassEntry entries [BypassDepth];
    PipelinePkg::BypassEntry execEntry;
    PipelinePkg::BypassEntry loadEntry;

    assign execEntry = '{valid: writeEnable, addr: writeAddr, value: writeValue};
    assign loadEntry = '{valid: loadWriteEnable, addr: loadWriteAddr, value: loadWriteValue};

    // x0 first, then the load port, then the youngest matching entry
    function automatic IsaPkg::word_t lookup(IsaPkg::regAddr_t addr,
                                             IsaPkg::word_t regValue);
        IsaPkg::word_t value;
        value = regValue;
        // Walk oldest to youngest so the lowest hit overrides
        for (int j = BypassDepth - 1; j >= 0; j--) begin
            if (entries[j].valid && entries[j].addr == addr) begin
                value = entries[j].value;
            end
        end
        if (loadWriteEnable && loadWriteAddr == addr) begin
            value = loadWriteValue;
        end
        if (addr == '0) begin
            value = '0;
        end
        return value;
    endfunction

    always_comb begin
        operand1 = lookup(readAddr1, regValue1);
    end

    always_comb begin
        operand2 = lookup(readAddr2, regValue2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BypassDepth; i++) begin
                entries[i] <= '0;
            end
        end else if (!stall) begin
            entries[0] <= execEntry;
            // A load result joins the pipeline late, in place of its empty slot
            if (loadWriteEnable) begin
                entries[1] <= loadEntry;
            end else begin
                entries[1] <= entries[0];
            end
            for (int i = 2; i < BypassDepth; i++) begin
                entries[i] <= entries[i-1];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/ExecuteStage.sv
`timescale 1ns/10ps
`default_nettype none

module ExecuteStage #(
    parameter int BypassDepth = 2
) (
    input wire clk,
    input wire rst,
    input wire advance,
    input wire exValid,
    input wire IsaPkg::MicroOp exOp,
    output IsaPkg::regAddr_t regAddr1,
    output IsaPkg::regAddr_t regAddr2,
    input wire IsaPkg::word_t regValue1,
    input wire IsaPkg::word_t regValue2,
    input wire loadWriteEnable,
    input wire IsaPkg::regAddr_t loadWriteAddr,
    input wire IsaPkg::word_t loadWriteValue,
    output PipelinePkg::MemStageReg memReg
);

    IsaPkg::word_t operand1;
    IsaPkg::word_t operand2;
    IsaPkg::word_t aluResult;
    logic bypassWrite;
    PipelinePkg::MemStageReg memNext;

    assign regAddr1 = exOp.rs1;
    assign regAddr2 = exOp.rs2;

    // Loads forward later through the load port, stores produce nothing
    assign bypassWrite = exValid && IsaPkg::isAluOp(exOp.op) && exOp.rd != '0;

    BypassNetwork #(
        .BypassDepth(BypassDepth)
    ) bypass (
        .clk(clk),
        .rst(rst),
        .stall(!advance),
        .readAddr1(exOp.rs1),
        .readAddr2(exOp.rs2),
        .regValue1(regValue1),
        .regValue2(regValue2),
        .operand1(operand1),
        .operand2(operand2),
        .writeEnable(bypassWrite),
        .writeAddr(exOp.rd),
        .writeValue(aluResult),
        .loadWriteEnable(loadWriteEnable),
        .loadWriteAddr(loadWriteAddr),
        .loadWriteValue(loadWriteValue)
    );

    always_comb begin
        unique case (exOp.op)
            IsaPkg::OpAdd: aluResult = operand1 + operand2;
            IsaPkg::OpSub: aluResult = operand1 - operand2;
            IsaPkg::OpAnd: aluResult = operand1 & operand2;
            IsaPkg::OpOr:  aluResult = operand1 | operand2;
            IsaPkg::OpXor: aluResult = operand1 ^ operand2;
            IsaPkg::OpSll: aluResult = operand1 << operand2[4:0];
            // addi and the lw/sw address
            default:       aluResult = operand1 + exOp.imm;
        endcase
    end

    always_comb begin
        memNext.valid = exValid;
        memNext.op = exOp.op;
        memNext.rd = exOp.rd;
        memNext.result = aluResult;
        memNext.storeData = operand2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            memReg.valid <= 1'b0;
        end else if (advance) begin
            memReg <= memNext;
        end
    end

endmodule

`default_nettype wire

//--- rtl/MemoryStage.sv
`timescale 1ns/10ps
`default_nettype none

module MemoryStage #(
    parameter int DataWords = 64
) (
    input wire clk,
    input wire rst,
    input wire advance,
    input wire PipelinePkg::MemStageReg memReg,
    output logic loadWriteEnable,
    output IsaPkg::regAddr_t loadWriteAddr,
    output IsaPkg::word_t loadWriteValue,
    output logic retireValid,
    input wire retireReady,
    output PipelinePkg::RetireRecord retireRec,
    output logic rfWriteEnable,
    output IsaPkg::regAddr_t rfWriteAddr,
    output IsaPkg::word_t rfWriteValue
);

    localparam int IndexBits = $clog2(DataWords);

    IsaPkg::word_t dataMem [DataWords];
    logic [IndexBits-1:0] wordIndex;
    logic isLoad;
    logic isStore;
    PipelinePkg::RetireRecord retireNext;

    // Byte address, word index wraps at the memory depth
    assign wordIndex = memReg.result[IndexBits+1:2];
    assign isLoad = memReg.valid && memReg.op == IsaPkg::OpLw;
    assign isStore = memReg.valid && memReg.op == IsaPkg::OpSw;

    // Load data goes straight to the consumer now sitting in execute
    assign loadWriteEnable = isLoad && memReg.rd != '0;
    assign loadWriteAddr = memReg.rd;
    assign loadWriteValue = dataMem[wordIndex];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DataWords; i++) begin
                dataMem[i] <= '0;
            end
        end else if (advance && isStore) begin
            dataMem[wordIndex] <= memReg.storeData;
        end
    end

    always_comb begin
        retireNext.regWrite = !isStore && memReg.rd != '0;
        retireNext.rd = memReg.rd;
        if (isLoad) begin
            retireNext.value = dataMem[wordIndex];
        end else if (isStore) begin
            retireNext.value = memReg.storeData;
        end else begin
            retireNext.value = memReg.result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            retireValid <= 1'b0;
        end else if (advance) begin
            retireValid <= memReg.valid;
            retireRec <= retireNext;
        end
    end

    // Architectural write lands when the record leaves
    assign rfWriteEnable = retireValid && retireReady && retireRec.regWrite;
    assign rfWriteAddr = retireRec.rd;
    assign rfWriteValue = retireRec.value;

    assert property (@(posedge clk) disable iff (rst)
        retireValid && !retireReady |=> retireValid && $stable(retireRec))
    else $error("MemoryStage: retire record changed under back-pressure");

endmodule

`default_nettype wire

//--- rtl/IntPipeline.sv
`timescale 1ns/10ps
`default_nettype none

module IntPipeline #(
    parameter int BypassDepth = 2,
    parameter int DataWords = 64
) (
    input wire clk,
    input wire rst,
    input wire inValid,
    output logic inReady,
    input wire IsaPkg::MicroOp inOp,
    output logic retireValid,
    input wire retireReady,
    output PipelinePkg::RetireRecord retireRec
);

    logic advance;
    logic exValid;
    IsaPkg::MicroOp exOp;
    IsaPkg::regAddr_t regAddr1;
    IsaPkg::regAddr_t regAddr2;
    IsaPkg::word_t regValue1;
    IsaPkg::word_t regValue2;
    logic loadWriteEnable;
    IsaPkg::regAddr_t loadWriteAddr;
    IsaPkg::word_t loadWriteValue;
    PipelinePkg::MemStageReg memReg;
    logic rfWriteEnable;
    IsaPkg::regAddr_t rfWriteAddr;
    IsaPkg::word_t rfWriteValue;

    // One global enable, frozen only by a retire record that cannot leave
    assign advance = !retireValid || retireReady;

    IssueStage issue (
        .clk(clk),
        .rst(rst),
        .advance(advance),
        .inValid(inValid),
        .inOp(inOp),
        .inReady(inReady),
        .exValid(exValid),
        .exOp(exOp)
    );

    ExecuteStage #(
        .BypassDepth(BypassDepth)
    ) execute (
        .clk(clk),
        .rst(rst),
        .advance(advance),
        .exValid(exValid),
        .exOp(exOp),
        .regAddr1(regAddr1),
        .regAddr2(regAddr2),
        .regValue1(regValue1),
        .regValue2(regValue2),
        .loadWriteEnable(loadWriteEnable),
        .loadWriteAddr(loadWriteAddr),
        .loadWriteValue(loadWriteValue),
        .memReg(memReg)
    );

    MemoryStage #(
        .DataWords(DataWords)
    ) memory (
        .clk(clk),
        .rst(rst),
        .advance(advance),
        .memReg(memReg),
        .loadWriteEnable(loadWriteEnable),
        .loadWriteAddr(loadWriteAddr),
        .loadWriteValue(loadWriteValue),
        .retireValid(retireValid),
        .retireReady(retireReady),
        .retireRec(retireRec),
        .rfWriteEnable(rfWriteEnable),
        .rfWriteAddr(rfWriteAddr),
        .rfWriteValue(rfWriteValue)
    );

    RegFile regFile (
        .clk(clk),
        .rst(rst),
        .readAddr1(regAddr1),
        .readAddr2(regAddr2),
        .readValue1(regValue1),
        .readValue2(regValue2),
        .writeEnable(rfWriteEnable),
        .writeAddr(rfWriteAddr),
        .writeValue(rfWriteValue)
    );

endmodule

`default_nettype wire

//--- sim/RetireChecker.sv
`timescale 1ns/10ps
`default_nettype none

module RetireChecker #(
    parameter int RowCount = 28,
    parameter int WaitLimit = 100
) (
    input wire clk,
    input wire rst,
    input wire inValid,
    input wire inReady,
    input wire retireValid,
    input wire retireReady,
    input wire PipelinePkg::RetireRecord retireRec,
    input wire PipelinePkg::RetireRecord expected [RowCount],
    output logic done,
    output int failures
);

    int matched;
    logic stopped;

    // All sampling at the falling edge, where DUT outputs are settled
    task automatic waitResetRelease();
        int waited;
        waited = 0;
        @(negedge clk);
        while (rst && !stopped) begin
            waited++;
            if (waited > WaitLimit) begin
                $display("Timeout at %0t: reset was never released", $time);
                failures++;
                stopped = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic checkResetState();
        int waited;
        waited = 0;
        if (retireValid || !inReady) begin
            $display("Mismatch at %0t: after reset retireValid=%0b inReady=%0b, expected 0 and 1",
                     $time, retireValid, inReady);
            failures++;
        end else begin
            $display("Reset state ok: retire port empty, input ready");
        end
        // Nothing may retire before the first op is taken
        while (!(inValid && inReady) && !stopped) begin
            if (retireValid) begin
                $display("Mismatch at %0t: retireValid high before any micro-op", $time);
                failures++;
            end
            waited++;
            if (waited > WaitLimit) begin
                $display("Timeout at %0t: no micro-op was accepted after reset", $time);
                failures++;
                stopped = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    task automatic checkRow(input int row);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(retireValid && retireReady) && !stopped) begin
            waited++;
            if (waited > WaitLimit) begin
                $display("Timeout at %0t: row %0d did not retire within %0d cycles",
                         $time, row, WaitLimit);
                failures++;
                stopped = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        if (!stopped) begin
            if (retireRec !== expected[row]) begin
                $display("Mismatch at %0t: row %0d expected %0b/x%0d/%08h, got %0b/x%0d/%08h",
                         $time, row, expected[row].regWrite, expected[row].rd,
                         expected[row].value, retireRec.regWrite, retireRec.rd,
                         retireRec.value);
                failures++;
            end else begin
                matched++;
                $display("Row %0d ok: rd x%0d value %08h", row, retireRec.rd, retireRec.value);
            end
        end
    endtask

    // A duplicate would show up as one more record after the last row
    task automatic checkNoExtra();
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            if (retireValid) begin
                $display("Extra retire record seen at %0t after the last row", $time);
                failures++;
                break;
            end
        end
    endtask

    initial begin
        done = 1'b0;
        failures = 0;
        matched = 0;
        stopped = 1'b0;
        waitResetRelease();
        if (!stopped) begin
            checkResetState();
        end
        for (int row = 0; row < RowCount && !stopped; row++) begin
            checkRow(row);
        end
        if (!stopped) begin
            checkNoExtra();
        end
        $display("Summary: %0d of %0d rows matched, %0d errors", matched, RowCount, failures);
        done = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/IntPipelineTb.sv
`timescale 1ns/10ps
`default_nettype none

module IntPipelineTb;

    localparam int RowCount = 28;
    localparam int WaitLimit = 100;
    localparam int DoneLimit = 1000;

    logic clk;
    logic rst;
    logic inValid;
    logic inReady;
    IsaPkg::MicroOp inOp;
    logic retireValid;
    logic retireReady;
    PipelinePkg::RetireRecord retireRec;

    IsaPkg::MicroOp stimulus [RowCount];
    PipelinePkg::RetireRecord expected [RowCount];
    logic checkDone;
    int checkFailures;
    logic driveTimeout;

    IntPipeline #(
        .BypassDepth(2),
        .DataWords(64)
    ) uut (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .inOp(inOp),
        .retireValid(retireValid),
        .retireReady(retireReady),
        .retireRec(retireRec)
    );

    RetireChecker #(
        .RowCount(RowCount),
        .WaitLimit(WaitLimit)
    ) retireCheck (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .inReady(inReady),
        .retireValid(retireValid),
        .retireReady(retireReady),
        .retireRec(retireRec),
        .expected(expected),
        .done(checkDone),
        .failures(checkFailures)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Roughly one cycle in four the consumer holds off
    always @(posedge clk) begin
        retireReady <= ($urandom % 4) != 0;
    end

    task automatic setRow(input int row, input IsaPkg::opcode_t op, input int rd,
                          input int rs1, input int rs2, input IsaPkg::word_t imm,
                          input logic regWrite, input IsaPkg::word_t value);
        stimulus[row] = '{op: op, rd: rd[4:0], rs1: rs1[4:0], rs2: rs2[4:0], imm: imm};
        expected[row] = '{regWrite: regWrite, rd: rd[4:0], value: value};
    endtask

    task automatic buildTable();
        // Dependent ALU chain
        setRow(0, IsaPkg::OpAddi, 1, 0, 0, 32'd5, 1'b1, 32'd5);
        setRow(1, IsaPkg::OpAddi, 2, 1, 0, 32'd3, 1'b1, 32'd8);
        setRow(2, IsaPkg::OpAdd, 3, 2, 1, 32'd0, 1'b1, 32'd13);
        setRow(3, IsaPkg::OpSub, 4, 3, 2, 32'd0, 1'b1, 32'd5);
        setRow(4, IsaPkg::OpSll, 5, 4, 1, 32'd0, 1'b1, 32'd160);
        setRow(5, IsaPkg::OpXor, 6, 5, 3, 32'd0, 1'b1, 32'h0000_00ad);
        setRow(6, IsaPkg::OpAnd, 7, 6, 5, 32'd0, 1'b1, 32'h0000_00a0);
        setRow(7, IsaPkg::OpOr, 8, 7, 4, 32'd0, 1'b1, 32'h0000_00a5);
        // Older producers from the register file
        setRow(8, IsaPkg::OpAddi, 9, 1, 0, 32'hffff_ffff, 1'b1, 32'd4);
        setRow(9, IsaPkg::OpAdd, 10, 9, 9, 32'd0, 1'b1, 32'd8);
        // x0 as target, then read right behind it
        setRow(10, IsaPkg::OpAddi, 0, 1, 0, 32'd100, 1'b0, 32'd105);
        setRow(11, IsaPkg::OpAdd, 11, 0, 1, 32'd0, 1'b1, 32'd5);
        // Store, load of the same word, immediate consumer
        setRow(12, IsaPkg::OpSw, 3, 0, 8, 32'd16, 1'b0, 32'h0000_00a5);
        setRow(13, IsaPkg::OpLw, 12, 0, 0, 32'd16, 1'b1, 32'h0000_00a5);
        // Loaded register rewritten at once, so two copies of x12 are in flight
        setRow(14, IsaPkg::OpAdd, 12, 12, 1, 32'd0, 1'b1, 32'h0000_00aa);
        setRow(15, IsaPkg::OpAddi, 14, 12, 0, 32'd1, 1'b1, 32'h0000_00ab);
        setRow(16, IsaPkg::OpSw, 0, 1, 12, 32'd15, 1'b0, 32'h0000_00aa);
        // Two loads feeding one op
        setRow(17, IsaPkg::OpLw, 15, 0, 0, 32'd20, 1'b1, 32'h0000_00aa);
        setRow(18, IsaPkg::OpLw, 16, 0, 0, 32'd16, 1'b1, 32'h0000_00a5);
        setRow(19, IsaPkg::OpSub, 17, 16, 15, 32'd0, 1'b1, 32'hffff_fffb);
        setRow(20, IsaPkg::OpSll, 18, 17, 2, 32'd0, 1'b1, 32'hffff_fb00);
        // Load into x0 must not leak through the load port
        setRow(21, IsaPkg::OpLw, 0, 0, 0, 32'd16, 1'b0, 32'h0000_00a5);
        setRow(22, IsaPkg::OpAdd, 19, 0, 0, 32'd0, 1'b1, 32'd0);
        setRow(23, IsaPkg::OpAddi, 20, 19, 0, 32'h0000_07ff, 1'b1, 32'h0000_07ff);
        setRow(24, IsaPkg::OpXor, 21, 20, 18, 32'd0, 1'b1, 32'hffff_fcff);
        setRow(25, IsaPkg::OpSw, 0, 2, 21, 32'd0, 1'b0, 32'hffff_fcff);
        setRow(26, IsaPkg::OpLw, 22, 0, 0, 32'd8, 1'b1, 32'hffff_fcff);
        setRow(27, IsaPkg::OpAnd, 23, 22, 7, 32'd0, 1'b1, 32'h0000_00a0);
    endtask

    initial begin
        int idleCycles;
        int waited;
        void'($urandom(32'h6054_d2a0));
        rst = 1'b1;
        inValid = 1'b0;
        inOp = '0;
        retireReady = 1'b0;
        driveTimeout = 1'b0;
        buildTable();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        // Quiet gap so the empty retire port can be observed
        repeat (3) @(posedge clk);
        for (int row = 0; row < RowCount && !driveTimeout; row++) begin
            idleCycles = ($urandom % 3 == 0) ? 1 + $urandom % 2 : 0;
            repeat (idleCycles) begin
                inValid <= 1'b0;
                @(posedge clk);
            end
            inValid <= 1'b1;
            inOp <= stimulus[row];
            waited = 0;
            @(negedge clk);
            while (!inReady && !driveTimeout) begin
                waited++;
                if (waited > WaitLimit) begin
                    $display("Timeout at %0t: row %0d was not accepted within %0d cycles",
                             $time, row, WaitLimit);
                    driveTimeout = 1'b1;
                end else begin
                    @(negedge clk);
                end
            end
            // The op is taken at this edge
            @(posedge clk);
        end
        inValid <= 1'b0;
        waited = 0;
        while (!checkDone && !driveTimeout && waited <= DoneLimit) begin
            @(posedge clk);
            waited++;
        end
        if (!checkDone && !driveTimeout) begin
            $display("Timeout: the retire checker did not finish within %0d cycles", DoneLimit);
        end
        if (checkDone && checkFailures == 0 && !driveTimeout) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- IntPipeline.f
rtl/IsaPkg.sv
rtl/PipelinePkg.sv
rtl/IssueStage.sv
rtl/RegFile.sv
rtl/BypassNetwork.sv
rtl/ExecuteStage.sv
rtl/MemoryStage.sv
rtl/IntPipeline.sv
sim/RetireChecker.sv
sim/IntPipelineTb.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in its output
verilator --binary --assert -Wno-fatal --top-module IntPipelineTb -f IntPipeline.f &&
    ./obj_dir/VIntPipelineTb | tee /dev/stderr | grep -qx "sim passed" &&
    echo "Run succeeded" ||
    { echo "Run did not pass"; exit 1; }
